/* rtl/cosine_pkg.sv */
// Cosine similarity package with the shared widths, controller states and payload structs
`default_nettype none

package cosine_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////////

  // One signed input element
  localparam int DATA_W = 8;

  // Dot and norm accumulators
  // 16 full-scale products reach at most 2^18
  localparam int ACC_W = 20;

  // Squared cosine in Q1.15 where 32768 stands for 1.0
  localparam int COS_W = 16;

  //////////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////////

  // One A/B element pair on its way to the MAC
  typedef struct packed {
    logic signed [DATA_W-1:0] a;
    logic signed [DATA_W-1:0] b;
    logic                     last;
  } element_pair_t;

  // Final sums of one vector pair
  typedef struct packed {
    logic signed [ACC_W-1:0] dot;
    logic        [ACC_W-1:0] norm_a;
    logic        [ACC_W-1:0] norm_b;
  } acc_sums_t;

  // Per-vector result with the sign carried by the dot product
  typedef struct packed {
    logic signed [ACC_W-1:0] dot;
    logic        [COS_W-1:0] cos_sq;
  } cos_result_t;

  // Controller FSM
  typedef enum logic [1:0] {
    STATE_IDLE,
    STATE_COLLECT,
    STATE_DIVIDE,
    STATE_DONE
  } cos_state_e;

endpackage

`default_nettype wire

/* rtl/cosine_element_capture.sv */
// Element capture that pairs A and B elements arriving on independent strobes
`default_nettype none

module cosine_element_capture (
  input  wire logic                                    CLK,
  input  wire logic                                    RST,
  input  wire logic                                    capture_enable,
  input  wire logic                                    a_enable,
  input  wire logic                                    b_enable,
  input  wire logic                                    pair_last,
  input  wire logic signed [cosine_pkg::DATA_W-1:0]    data_a,
  input  wire logic signed [cosine_pkg::DATA_W-1:0]    data_b,
  output logic                                         pair_valid,
  output cosine_pkg::element_pair_t                    pair
);

  // Held operands
  logic signed [cosine_pkg::DATA_W-1:0] a_q;
  logic signed [cosine_pkg::DATA_W-1:0] b_q;
  logic                                 a_held;
  logic                                 b_held;

  // Operand as seen this cycle
  logic                                 a_seen;
  logic                                 b_seen;
  logic signed [cosine_pkg::DATA_W-1:0] a_next;
  logic signed [cosine_pkg::DATA_W-1:0] b_next;

  // A fresh strobe wins over the held value
  always_comb begin
    a_seen = a_held | a_enable;
    b_seen = b_held | b_enable;
    a_next = a_enable ? data_a : a_q;
    b_next = b_enable ? data_b : b_q;
  end

  // Flags and pair strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      a_held     <= 1'b0;
      b_held     <= 1'b0;
      pair_valid <= 1'b0;
    end else if (!capture_enable) begin
      // Strobes outside collection are dropped
      a_held     <= 1'b0;
      b_held     <= 1'b0;
      pair_valid <= 1'b0;
    end else if (a_seen && b_seen) begin
      a_held     <= 1'b0;
      b_held     <= 1'b0;
      pair_valid <= 1'b1;
    end else begin
      a_held     <= a_seen;
      b_held     <= b_seen;
      pair_valid <= 1'b0;
    end
  end

  // Operand and pair registers
  always_ff @(posedge CLK) begin
    if (capture_enable) begin
      a_q <= a_next;
      b_q <= b_next;
      if (a_seen && b_seen) begin
        pair.a    <= a_next;
        pair.b    <= b_next;
        pair.last <= pair_last;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/cosine_mac.sv */
// MAC that accumulates the dot product and both squared norms of one vector pair
`default_nettype none

module cosine_mac (
  input  wire logic                      CLK,
  input  wire logic                      RST,
  input  wire logic                      pair_valid,
  input  wire cosine_pkg::element_pair_t pair,
  output logic                           sums_valid,
  output cosine_pkg::acc_sums_t          sums,
  output logic                           element_done
);

  ////////////////////////////////////////////////////////////////////////////
  // Products
  ////////////////////////////////////////////////////////////////////////////

  // Full-width element products
  logic signed [2*cosine_pkg::DATA_W-1:0] prod_ab;
  logic        [2*cosine_pkg::DATA_W-1:0] sq_a;
  logic        [2*cosine_pkg::DATA_W-1:0] sq_b;

  // Running and next sums
  cosine_pkg::acc_sums_t acc_q;
  cosine_pkg::acc_sums_t acc_next;

  always_comb begin
    prod_ab = pair.a * pair.b;
    // Squares are never negative
    sq_a    = pair.a * pair.a;
    sq_b    = pair.b * pair.b;

    // Dot extends with sign, norms with zeros
    acc_next.dot    = acc_q.dot + cosine_pkg::ACC_W'(prod_ab);
    acc_next.norm_a = acc_q.norm_a + cosine_pkg::ACC_W'(sq_a);
    acc_next.norm_b = acc_q.norm_b + cosine_pkg::ACC_W'(sq_b);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Accumulators
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc_q        <= '0;
      sums_valid   <= 1'b0;
      element_done <= 1'b0;
    end else begin
      // One pulse per accumulated element
      element_done <= pair_valid;
      sums_valid   <= pair_valid & pair.last;
      if (pair_valid) begin
        // Restart from zero after the final element
        acc_q <= pair.last ? '0 : acc_next;
      end
    end
  end

  // Final sums, held until the next vector ends
  always_ff @(posedge CLK) begin
    if (pair_valid && pair.last) begin
      sums <= acc_next;
    end
  end

endmodule

`default_nettype wire

/* rtl/cosine_divider.sv */
// Restoring divider that forms the squared cosine from the dot product and both norms
`default_nettype none

module cosine_divider (
  input  wire logic                         CLK,
  input  wire logic                         RST,
  input  wire logic                         div_start,
  input  wire cosine_pkg::acc_sums_t        sums,
  output logic                              div_done,
  output logic [cosine_pkg::COS_W-1:0]      cos_sq
);

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Products of two accumulators
  localparam int PROD_W = 2 * cosine_pkg::ACC_W;
  // Dividend carries the Q1.15 shift
  localparam int NUM_W  = PROD_W + cosine_pkg::COS_W - 1;
  // Counts 0 .. COS_W
  localparam int STEP_W = $clog2(cosine_pkg::COS_W + 1);

  // Operands formed at load
  logic [PROD_W-1:0] dot_sq;
  logic [PROD_W-1:0] norm_prod;

  // Iteration registers
  logic [NUM_W-1:0]              rem_q;
  logic [NUM_W-1:0]              dsr_q;
  logic [cosine_pkg::COS_W-1:0]  quot_q;
  logic                          zero_q;
  logic                          fits;

  // Sequencing
  logic              busy;
  logic [STEP_W-1:0] step;
  logic              last_step;

  always_comb begin
    // Signed square, widened before the multiply
    dot_sq    = sums.dot * sums.dot;
    norm_prod = sums.norm_a * sums.norm_b;
    fits      = (rem_q >= dsr_q);
    last_step = (step == STEP_W'(cosine_pkg::COS_W));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  // 1 load edge, 16 iteration edges, 1 output edge
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      step     <= '0;
      div_done <= 1'b0;
    end else begin
      div_done <= 1'b0;
      if (div_start) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        if (last_step) begin
          busy     <= 1'b0;
          div_done <= 1'b1;
        end else begin
          step <= step + STEP_W'(1);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (div_start) begin
      // Quotient bit 15 weighs the divisor shifted by 15
      rem_q  <= {dot_sq, {(cosine_pkg::COS_W-1){1'b0}}};
      dsr_q  <= {norm_prod, {(cosine_pkg::COS_W-1){1'b0}}};
      quot_q <= '0;
      zero_q <= (norm_prod == '0);
    end else if (busy && !last_step) begin
      // Subtract only when it fits, otherwise restore
      if (fits) begin
        rem_q <= rem_q - dsr_q;
      end
      quot_q <= {quot_q[cosine_pkg::COS_W-2:0], fits};
      dsr_q  <= dsr_q >> 1;
    end
    // Zero norm gives zero similarity
    if (busy && last_step) begin
      cos_sq <= zero_q ? '0 : quot_q;
    end
  end

endmodule

`default_nettype wire

/* rtl/cosine_similarity_ctrl.sv */
// Controller that runs the vector and element loops and sequences capture, MAC and divider
`default_nettype none

module cosine_similarity_ctrl #(
  parameter int MAX_SIZE   = 8,
  parameter int MAX_LENGTH = 16
) (
  input  wire logic                                CLK,
  input  wire logic                                RST,
  input  wire logic                                start,
  input  wire logic [$clog2(MAX_SIZE+1)-1:0]       size,
  input  wire logic [$clog2(MAX_LENGTH+1)-1:0]     length,
  input  wire logic                                element_done,
  input  wire logic                                sums_valid,
  input  wire cosine_pkg::acc_sums_t               sums,
  input  wire logic                                div_done,
  input  wire logic [cosine_pkg::COS_W-1:0]        cos_sq,
  output logic                                     capture_enable,
  output logic                                     pair_last,
  output logic                                     div_start,
  output logic                                     vector_done,
  output logic                                     ready,
  output cosine_pkg::cos_result_t                  result
);

  localparam int SIZE_W   = $clog2(MAX_SIZE + 1);
  localparam int LENGTH_W = $clog2(MAX_LENGTH + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  cosine_pkg::cos_state_e state;

  // Run configuration, sampled at start
  logic [SIZE_W-1:0]   size_q;
  logic [LENGTH_W-1:0] length_q;

  // Loop indices
  logic [SIZE_W-1:0]   vec_idx;
  logic [LENGTH_W-1:0] elem_idx;
  logic                last_vector;

  // Dot product waiting for its cosine
  logic signed [cosine_pkg::ACC_W-1:0] dot_q;

  always_comb begin
    capture_enable = (state == cosine_pkg::STATE_COLLECT);
    pair_last      = (elem_idx == length_q - LENGTH_W'(1));
    last_vector    = (vec_idx == size_q - SIZE_W'(1));
    // Divider loads on the edge that ends the sums cycle
    div_start      = capture_enable & sums_valid;
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= cosine_pkg::STATE_IDLE;
      size_q      <= '0;
      length_q    <= '0;
      vec_idx     <= '0;
      elem_idx    <= '0;
      vector_done <= 1'b0;
      ready       <= 1'b0;
    end else begin
      // Output strobes last one cycle
      vector_done <= 1'b0;
      ready       <= 1'b0;
      case (state)
        cosine_pkg::STATE_IDLE: begin
          if (start) begin
            size_q   <= size;
            length_q <= length;
            vec_idx  <= '0;
            elem_idx <= '0;
            state    <= cosine_pkg::STATE_COLLECT;
          end
        end
        cosine_pkg::STATE_COLLECT: begin
          // Element loop
          if (element_done) begin
            elem_idx <= pair_last ? '0 : elem_idx + LENGTH_W'(1);
          end
          // Last element accumulated
          if (sums_valid) begin
            state <= cosine_pkg::STATE_DIVIDE;
          end
        end
        cosine_pkg::STATE_DIVIDE: begin
          if (div_done) begin
            vector_done <= 1'b1;
            ready       <= last_vector;
            state       <= cosine_pkg::STATE_DONE;
          end
        end
        cosine_pkg::STATE_DONE: begin
          // Vector loop
          if (last_vector) begin
            state <= cosine_pkg::STATE_IDLE;
          end else begin
            vec_idx <= vec_idx + SIZE_W'(1);
            state   <= cosine_pkg::STATE_COLLECT;
          end
        end
        default: begin
          state <= cosine_pkg::STATE_IDLE;
        end
      endcase
    end
  end

  // Result assembly
  always_ff @(posedge CLK) begin
    if (div_start) begin
      dot_q <= sums.dot;
    end
    if (state == cosine_pkg::STATE_DIVIDE && div_done) begin
      result.dot    <= dot_q;
      result.cos_sq <= cos_sq;
    end
  end

endmodule

`default_nettype wire

/* rtl/vector_cosine_similarity.sv */
// Top level of the vector cosine similarity block, wires capture, MAC, divider and FSM
`default_nettype none

module vector_cosine_similarity #(
  parameter int MAX_SIZE   = 8,
  parameter int MAX_LENGTH = 16
) (
  input  wire logic                                  CLK,
  input  wire logic                                  RST,
  input  wire logic                                  start,
  input  wire logic [$clog2(MAX_SIZE+1)-1:0]         size,
  input  wire logic [$clog2(MAX_LENGTH+1)-1:0]       length,
  input  wire logic                                  a_enable,
  input  wire logic                                  b_enable,
  input  wire logic signed [cosine_pkg::DATA_W-1:0]  data_a,
  input  wire logic signed [cosine_pkg::DATA_W-1:0]  data_b,
  output logic                                       element_done,
  output logic                                       vector_done,
  output logic                                       ready,
  output cosine_pkg::cos_result_t                    result
);

  // Capture side
  logic                         capture_enable;
  logic                         pair_last;
  logic                         pair_valid;
  cosine_pkg::element_pair_t    pair;

  // MAC to divider
  logic                         sums_valid;
  cosine_pkg::acc_sums_t        sums;
  logic                         div_start;
  logic                         div_done;
  logic [cosine_pkg::COS_W-1:0] cos_sq;

  cosine_element_capture u_capture (
    .CLK            (CLK),
    .RST            (RST),
    .capture_enable (capture_enable),
    .a_enable       (a_enable),
    .b_enable       (b_enable),
    .pair_last      (pair_last),
    .data_a         (data_a),
    .data_b         (data_b),
    .pair_valid     (pair_valid),
    .pair           (pair)
  );

  cosine_mac u_mac (
    .CLK          (CLK),
    .RST          (RST),
    .pair_valid   (pair_valid),
    .pair         (pair),
    .sums_valid   (sums_valid),
    .sums         (sums),
    .element_done (element_done)
  );

  cosine_divider u_divider (
    .CLK       (CLK),
    .RST       (RST),
    .div_start (div_start),
    .sums      (sums),
    .div_done  (div_done),
    .cos_sq    (cos_sq)
  );

  // Loop widths follow the top-level limits
  cosine_similarity_ctrl #(
    .MAX_SIZE   (MAX_SIZE),
    .MAX_LENGTH (MAX_LENGTH)
  ) u_ctrl (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .size           (size),
    .length         (length),
    .element_done   (element_done),
    .sums_valid     (sums_valid),
    .sums           (sums),
    .div_done       (div_done),
    .cos_sq         (cos_sq),
    .capture_enable (capture_enable),
    .pair_last      (pair_last),
    .div_start      (div_start),
    .vector_done    (vector_done),
    .ready          (ready),
    .result         (result)
  );

endmodule

`default_nettype wire

/* testbench/vector_cosine_similarity_checker.sv */
// Concurrent assertions on strobes and divider timing of the cosine similarity top level
`default_nettype none

module vector_cosine_similarity_checker #(
  parameter int MAX_SIZE = 8
) (
  input wire logic                          CLK,
  input wire logic                          RST,
  input wire logic                          start,
  input wire logic [$clog2(MAX_SIZE+1)-1:0] size,
  input wire logic                          capture_enable,
  input wire logic                          pair_valid,
  input wire logic                          sums_valid,
  input wire logic                          div_start,
  input wire logic                          div_done,
  input wire logic                          element_done,
  input wire logic                          vector_done,
  input wire logic                          ready
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SIZE_W = $clog2(MAX_SIZE + 1);

  // Failed assertions so far
  int fail_count = 0;

  // Vectors still owed by the current run
  logic [SIZE_W-1:0] vectors_left;

  // Loaded when a run starts and counted down per vector
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      vectors_left <= '0;
    end else if (start && vectors_left == '0) begin
      vectors_left <= size;
    end else if (vector_done && vectors_left != '0) begin
      vectors_left <= vectors_left - SIZE_W'(1);
    end
  end

  // capture_enable is high only in the collect state
  element_done_in_collect: assert property (
    @(posedge CLK) disable iff (RST) element_done |-> capture_enable
  ) else begin
    $error("element_done pulsed outside the collect state");
    fail_count++;
  end

  // Load, 16 steps, output
  divider_latency: assert property (
    @(posedge CLK) disable iff (RST) div_start |=> (!div_done [*17]) ##1 div_done
  ) else begin
    $error("div_done did not follow div_start after 18 cycles");
    fail_count++;
  end

  // ready pulses only with the last vector_done of a run
  ready_on_last_vector: assert property (
    @(posedge CLK) disable iff (RST) (ready || vector_done) |->
      (vector_done && (ready == (vectors_left == SIZE_W'(1))))
  ) else begin
    $error("ready did not coincide with the last vector_done of the run");
    fail_count++;
  end

  // One edge for the reset to settle
  quiet_in_reset: assert property (
    @(posedge CLK) RST && $past(RST) |->
      !(pair_valid || sums_valid || div_start || div_done ||
        element_done || vector_done || ready)
  ) else begin
    $error("a strobe was high during reset");
    fail_count++;
  end

endmodule

`default_nettype wire

/* testbench/cosine_model.svh */
// Reference model for the cosine similarity block, vector sums and Q1.15 squared cosine
`ifndef COSINE_MODEL_SVH
`define COSINE_MODEL_SVH

// Longest vector the model holds
localparam int MODEL_LEN = 16;

// Signed dot product of the first len elements
function automatic longint dot_product(input int va [MODEL_LEN], input int vb [MODEL_LEN],
                                       input int len);
  longint sum;
  sum = 0;
  for (int i = 0; i < len; i++) begin
    sum += longint'(va[i]) * longint'(vb[i]);
  end
  return sum;
endfunction

// Sum of squares of the first len elements
function automatic longint squared_norm(input int v [MODEL_LEN], input int len);
  longint sum;
  sum = 0;
  for (int i = 0; i < len; i++) begin
    sum += longint'(v[i]) * longint'(v[i]);
  end
  return sum;
endfunction

// floor(dot^2 * 2^15 / (norm_a * norm_b)), 0 for a zero divisor
function automatic int squared_cosine(input longint dot, input longint na, input longint nb);
  longint divisor;
  divisor = na * nb;
  if (divisor == 0) begin
    return 0;
  end
  return int'((dot * dot * 64'sd32768) / divisor);
endfunction

`endif

/* testbench/vector_cosine_similarity_tb.sv */
// Testbench for the vector cosine similarity block with random runs checked against a model
`default_nettype none

module vector_cosine_similarity_tb;
  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////////////////////////////////////////
  // Parameters and signals
  ////////////////////////////////////////////////////////////////////////////

  // DUT defaults
  localparam int MAX_SIZE   = 8;
  localparam int MAX_LENGTH = 16;
  localparam int SIZE_W     = $clog2(MAX_SIZE + 1);
  localparam int LENGTH_W   = $clog2(MAX_LENGTH + 1);

  // Data kinds
  localparam int KIND_RANDOM    = 0;
  localparam int KIND_IDENTICAL = 1;
  localparam int KIND_NEGATED   = 2;
  localparam int KIND_ZERO      = 3;
  localparam int KIND_FULL      = 4;
  localparam int KIND_CORNER    = 5;

  // Strobe orders
  localparam int STROBE_SAME    = 0;
  localparam int STROBE_A_FIRST = 1;
  localparam int STROBE_B_FIRST = 2;
  localparam int STROBE_MIXED   = 3;

  `include "cosine_model.svh"

  logic                        CLK;
  logic                        RST;
  logic                        start;
  logic [SIZE_W-1:0]           size;
  logic [LENGTH_W-1:0]         length;
  logic                        a_enable;
  logic                        b_enable;
  logic signed [7:0]           data_a;
  logic signed [7:0]           data_b;
  logic                        element_done;
  logic                        vector_done;
  logic                        ready;
  cosine_pkg::cos_result_t     result;

  int seed          = 32893;
  int errors        = 0;
  int checks        = 0;
  int cycle_count   = 0;
  int timeout_limit = 400;
  int element_count = 0;
  int vector_count  = 0;
  int ready_count   = 0;
  int vec_a [MODEL_LEN];
  int vec_b [MODEL_LEN];

  vector_cosine_similarity UUT (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .size         (size),
    .length       (length),
    .a_enable     (a_enable),
    .b_enable     (b_enable),
    .data_a       (data_a),
    .data_b       (data_b),
    .element_done (element_done),
    .vector_done  (vector_done),
    .ready        (ready),
    .result       (result)
  );

  bind vector_cosine_similarity vector_cosine_similarity_checker #(
    .MAX_SIZE (MAX_SIZE)
  ) u_checker (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .size           (size),
    .capture_enable (capture_enable),
    .pair_valid     (pair_valid),
    .sums_valid     (sums_valid),
    .div_start      (div_start),
    .div_done       (div_done),
    .element_done   (element_done),
    .vector_done    (vector_done),
    .ready          (ready)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Pulse counters sampled mid-cycle
  always @(negedge CLK) begin
    if (element_done) begin
      element_count++;
    end
    if (vector_done) begin
      vector_count++;
    end
    if (ready) begin
      ready_count++;
    end
  end

  // Budget grows with every run
  initial begin
    while (cycle_count <= timeout_limit) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("Timeout: no end of test within %0d cycles", timeout_limit);
    $display("Test FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'({$random(seed)} % (hi - lo + 1));
  endfunction

  task automatic check_value(input string name, input longint expected, input longint actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("ERROR %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  // Drives one element pair and waits for its element_done
  task automatic send_element(input int a, input int b, input int mode);
    int gap;
    gap = rand_range(0, 3);
    @(posedge CLK);
    data_a   <= a[7:0];
    data_b   <= b[7:0];
    a_enable <= (mode != STROBE_B_FIRST);
    b_enable <= (mode != STROBE_A_FIRST);
    @(posedge CLK);
    a_enable <= 1'b0;
    b_enable <= 1'b0;
    if (mode != STROBE_SAME) begin
      repeat (gap) @(posedge CLK);
      // Second half of the pair
      a_enable <= (mode == STROBE_B_FIRST);
      b_enable <= (mode == STROBE_A_FIRST);
      @(posedge CLK);
      a_enable <= 1'b0;
      b_enable <= 1'b0;
    end
    do begin
      @(negedge CLK);
    end while (!element_done);
  endtask

  task automatic fill_vectors(input int kind, input int n_elem);
    for (int e = 0; e < n_elem; e++) begin
      case (kind)
        KIND_IDENTICAL: begin
          vec_a[e] = rand_range(1, 127) * (rand_range(0, 1) ? 1 : -1);
          vec_b[e] = vec_a[e];
        end
        KIND_NEGATED: begin
          vec_a[e] = rand_range(1, 127) * (rand_range(0, 1) ? 1 : -1);
          vec_b[e] = -vec_a[e];
        end
        KIND_ZERO: begin
          vec_a[e] = 0;
          vec_b[e] = rand_range(-128, 127);
        end
        KIND_FULL: begin
          vec_a[e] = rand_range(0, 1) ? 127 : -128;
          vec_b[e] = rand_range(0, 1) ? 127 : -128;
        end
        KIND_CORNER: begin
          vec_a[e] = -128;
          vec_b[e] = -128;
        end
        default: begin
          vec_a[e] = rand_range(-128, 127);
          vec_b[e] = rand_range(-128, 127);
        end
      endcase
    end
  endtask

  // One whole run of n_vec vector pairs
  task automatic run_test(input string name, input int n_vec, input int n_elem,
                          input int kind, input int strobe);
    int     elem_before;
    int     vec_before;
    int     ready_before;
    int     exp_cos;
    longint dot;
    string  tag;
    timeout_limit += n_vec * (n_elem * 8 + 25);
    elem_before  = element_count;
    vec_before   = vector_count;
    ready_before = ready_count;
    @(posedge CLK);
    start  <= 1'b1;
    size   <= SIZE_W'(n_vec);
    length <= LENGTH_W'(n_elem);
    @(posedge CLK);
    start  <= 1'b0;
    for (int v = 0; v < n_vec; v++) begin
      fill_vectors(kind, n_elem);
      dot     = dot_product(vec_a, vec_b, n_elem);
      exp_cos = squared_cosine(dot, squared_norm(vec_a, n_elem), squared_norm(vec_b, n_elem));
      for (int e = 0; e < n_elem; e++) begin
        send_element(vec_a[e], vec_b[e], (strobe == STROBE_MIXED) ? rand_range(0, 2) : strobe);
      end
      do begin
        @(negedge CLK);
      end while (!vector_done);
      tag = $sformatf("%s vector %0d", name, v);
      check_value({tag, " dot"}, dot, result.dot);
      check_value({tag, " cos_sq"}, exp_cos, result.cos_sq);
      check_value({tag, " ready"}, v == n_vec - 1, ready);
      // Extremes against fixed values
      if (kind == KIND_IDENTICAL || kind == KIND_CORNER) begin
        check_value({tag, " full similarity"}, 32768, result.cos_sq);
        check_value({tag, " dot positive"}, 1, result.dot > 0);
      end
      if (kind == KIND_NEGATED) begin
        check_value({tag, " full similarity"}, 32768, result.cos_sq);
        check_value({tag, " dot negative"}, 1, result.dot < 0);
      end
      if (kind == KIND_ZERO) begin
        check_value({tag, " zero similarity"}, 0, result.cos_sq);
      end
    end
    repeat (2) @(posedge CLK);
    check_value({name, " element_done count"}, n_vec * n_elem, element_count - elem_before);
    check_value({name, " vector_done count"}, n_vec, vector_count - vec_before);
    check_value({name, " ready count"}, 1, ready_count - ready_before);
  endtask

  // Strobes with no run active
  task automatic idle_strobes();
    int count_before;
    count_before = element_count;
    @(posedge CLK);
    a_enable <= 1'b1;
    b_enable <= 1'b1;
    data_a   <= 8'sd5;
    data_b   <= -8'sd7;
    @(posedge CLK);
    a_enable <= 1'b0;
    b_enable <= 1'b0;
    repeat (4) @(posedge CLK);
    check_value("idle strobes element_done", 0, element_count - count_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    RST      = 1'b1;
    start    = 1'b0;
    size     = '0;
    length   = '0;
    a_enable = 1'b0;
    b_enable = 1'b0;
    data_a   = '0;
    data_b   = '0;
    repeat (3) @(posedge CLK);
    RST <= 1'b0;

    idle_strobes();

    // Size limits at full scale
    run_test("size 1 length 1", 1, 1, KIND_FULL, STROBE_MIXED);
    run_test("size 1 length max", 1, MAX_LENGTH, KIND_FULL, STROBE_MIXED);
    run_test("size max length 1", MAX_SIZE, 1, KIND_FULL, STROBE_MIXED);
    run_test("size max length max", MAX_SIZE, MAX_LENGTH, KIND_FULL, STROBE_MIXED);
    run_test("all -128", 1, MAX_LENGTH, KIND_CORNER, STROBE_SAME);

    // Strobe orders
    run_test("a before b", 2, 6, KIND_RANDOM, STROBE_A_FIRST);
    run_test("b before a", 2, 6, KIND_RANDOM, STROBE_B_FIRST);
    run_test("same cycle", 2, 6, KIND_RANDOM, STROBE_SAME);

    // Extremes
    run_test("identical", 2, 8, KIND_IDENTICAL, STROBE_MIXED);
    run_test("negated", 2, 8, KIND_NEGATED, STROBE_MIXED);
    run_test("zero vector", 2, 8, KIND_ZERO, STROBE_MIXED);

    for (int i = 0; i < 20; i++) begin
      run_test($sformatf("random run %0d", i), rand_range(1, MAX_SIZE),
               rand_range(1, MAX_LENGTH), KIND_RANDOM, STROBE_MIXED);
    end

    idle_strobes();

    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, UUT.u_checker.fail_count);
    if (errors == 0 && UUT.u_checker.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+testbench
rtl/cosine_pkg.sv
rtl/cosine_element_capture.sv
rtl/cosine_mac.sv
rtl/cosine_divider.sv
rtl/cosine_similarity_ctrl.sv
rtl/vector_cosine_similarity.sv
testbench/vector_cosine_similarity_checker.sv
testbench/vector_cosine_similarity_tb.sv

/* Bender.yml */
package:
  name: vector_cosine_similarity

sources:
  - rtl/cosine_pkg.sv
  - rtl/cosine_element_capture.sv
  - rtl/cosine_mac.sv
  - rtl/cosine_divider.sv
  - rtl/cosine_similarity_ctrl.sv
  - rtl/vector_cosine_similarity.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/vector_cosine_similarity_checker.sv
      - testbench/vector_cosine_similarity_tb.sv
